/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= bpredTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* bpred/bpred.sv */
`timescale 1ns/1ns

// Branch prediction unit, fetch to execute
module bpred (
  input  logic         clk,
  input  logic         reset,
  input  logic         StallF,
  input  logic         StallD,
  input  logic         StallE,
  input  logic         FlushF,
  input  logic         FlushD,
  input  logic         FlushE,
  // Fetch side
  input  bpredPkg::pcT PCNextF,
  input  logic [31:0]  InstrF,
  output bpredPkg::pcT BPPredPCF,
  output logic         SelBPPredF,
  // Execute side
  input  bpredPkg::pcT PCE,
  input  bpredPkg::pcT PCD,
  input  bpredPkg::pcT PCTargetE,
  input  bpredPkg::pcT PCLinkE,
  input  logic         PCSrcE,
  output logic         BPPredWrongE
);

  logic [6:0]           opcodeF;
  logic [4:0]           rdF;
  logic [4:0]           rs1F;
  logic                 isJalF;
  logic                 isJalrF;
  bpredPkg::instrClassT classF;
  bpredPkg::dirStateT   dirPredF;
  bpredPkg::pcT         btbTargetF;
  logic                 btbValidF;
  bpredPkg::pcT         rasTopF;
  bpredPkg::stagePredT  stageF;
  bpredPkg::stagePredT  stageD;
  bpredPkg::stagePredT  stageE;
  logic                 commitE;
  bpredPkg::pcT         correctPCE;
  logic                 pcWrongE;
  logic                 dirWrongE;

  //////////////////////////////////////////////////
  // Class decode in F
  //////////////////////////////////////////////////

  // Uncompressed encodings only
  assign opcodeF = InstrF[6:0];
  assign rdF     = InstrF[11:7];
  assign rs1F    = InstrF[19:15];
  assign isJalF  = opcodeF == 7'h6F;
  assign isJalrF = opcodeF == 7'h67;

  // ret is jalr x0, 0(x1)
  assign classF.isReturn  = isJalrF && rs1F == 5'd1 && rdF == 5'd0;
  assign classF.isJumpReg = isJalrF && !classF.isReturn;
  assign classF.isJump    = isJalF;
  // Link into ra marks a call
  assign classF.isCall    = (isJalF || isJalrF) && rdF == 5'd1;
  assign classF.isBranch  = opcodeF == 7'h63;

  //////////////////////////////////////////////////
  // Predictors
  //////////////////////////////////////////////////

  // Table updates retire with E
  assign commitE = !StallE && !FlushE;

  dirPredictor u_dirPredictor (
    .clk        (clk),
    .reset      (reset),
    .lookupPC   (PCNextF),
    .prediction (dirPredF),
    .updatePC   (PCE),
    .updateEn   (stageE.instrClass.isBranch && commitE),
    .updateTaken(PCSrcE),
    .updateOld  (stageE.dirState)
  );

  // Holds targets of branches and both jump kinds
  btbPredictor u_btbPredictor (
    .clk         (clk),
    .reset       (reset),
    .lookupPC    (PCNextF),
    .target      (btbTargetF),
    .valid       (btbValidF),
    .updateEn    ((stageE.instrClass.isBranch || stageE.instrClass.isJump ||
                   stageE.instrClass.isJumpReg) && commitE),
    .updatePC    (PCE),
    .updateTarget(PCTargetE)
  );

  // Push at call resolve, pop once as the return leaves F
  rasPredictor u_rasPredictor (
    .clk   (clk),
    .reset (reset),
    .push  (stageE.instrClass.isCall && commitE),
    .pushPC(PCLinkE),
    .pop   (classF.isReturn && !StallF),
    .top   (rasTopF)
  );

  // Returns trust the RAS, everything else needs a BTB hit
  assign SelBPPredF = classF.isReturn ||
                      (btbValidF && ((classF.isBranch && dirPredF[1]) ||
                                     classF.isJump || classF.isJumpReg));
  assign BPPredPCF  = classF.isReturn ? rasTopF : btbTargetF;

  //////////////////////////////////////////////////
  // Stage registers F to D to E
  //////////////////////////////////////////////////

  assign stageF.dirState   = dirPredF;
  assign stageF.instrClass = classF;

  pipeStage #(.payloadT(bpredPkg::stagePredT)) u_stageD (
    .clk  (clk),
    .reset(reset),
    .en   (!StallF),
    .clear(FlushF),
    .d    (stageF),
    .q    (stageD)
  );

  pipeStage #(.payloadT(bpredPkg::stagePredT)) u_stageE (
    .clk  (clk),
    .reset(reset),
    .en   (!StallD),
    .clear(FlushD),
    .d    (stageD),
    .q    (stageE)
  );

  //////////////////////////////////////////////////
  // Misprediction check in E
  //////////////////////////////////////////////////

  // Where the instruction really went
  assign correctPCE = PCSrcE ? PCTargetE : PCLinkE;
  // PCD is the address fetch actually followed
  assign pcWrongE   = PCD != correctPCE;
  // Direction only matters for conditional branches
  assign dirWrongE  = stageE.instrClass.isBranch && (stageE.dirState[1] != PCSrcE);

  // Bubbles and plain instructions never flag
  assign BPPredWrongE = (stageE.instrClass != '0) && (pcWrongE || dirWrongE);

endmodule

/* bpred/btbPredictor.sv */
`timescale 1ns/1ns
`include "bpred_defs.svh"

// Direct-mapped branch target buffer
module btbPredictor (
  input  logic         clk,
  input  logic         reset,
  input  bpredPkg::pcT lookupPC,
  output bpredPkg::pcT target,
  output logic         valid,
  input  logic         updateEn,
  input  bpredPkg::pcT updatePC,
  input  bpredPkg::pcT updateTarget
);

  localparam int IndexBits = `BPRED_BTB_INDEX_BITS;
  localparam int Entries   = 1 << IndexBits;
  // Tag is everything above the index
  localparam int TagBits   = `BPRED_XLEN - IndexBits - 2;

  logic [IndexBits-1:0] lookupIndex;
  logic [IndexBits-1:0] updateIndex;
  logic [TagBits-1:0]   lookupTag;
  logic [TagBits-1:0]   updateTag;

  bpredPkg::pcT         targets [Entries];
  logic [TagBits-1:0]   tags    [Entries];
  logic [Entries-1:0]   valids;

  logic                 forward;
  logic                 hit;

  //////////////////////////////////////////////////
  // Address split
  //////////////////////////////////////////////////

  assign lookupIndex = lookupPC[IndexBits+1:2];
  assign lookupTag   = lookupPC[`BPRED_XLEN-1:IndexBits+2];
  assign updateIndex = updatePC[IndexBits+1:2];
  assign updateTag   = updatePC[`BPRED_XLEN-1:IndexBits+2];

  // Update to the very same PC as the lookup
  assign forward = updateEn && (updateIndex == lookupIndex) && (updateTag == lookupTag);

  // Stored entry matches the lookup
  assign hit = valids[lookupIndex] && (tags[lookupIndex] == lookupTag);

  //////////////////////////////////////////////////
  // Table write
  //////////////////////////////////////////////////

  // Valid bits and tags
  always_ff @(posedge clk) begin
    if (reset) begin
      valids <= '0;
      for (int i = 0; i < Entries; i++) begin
        tags[i] <= '0;
      end
    end else if (updateEn) begin
      valids[updateIndex] <= 1'b1;
      tags[updateIndex]   <= updateTag;
    end
  end

  // Target storage
  always_ff @(posedge clk) begin
    if (updateEn) begin
      targets[updateIndex] <= updateTarget;
    end
  end

  //////////////////////////////////////////////////
  // Registered lookup
  //////////////////////////////////////////////////

  // Result lands in the F cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else begin
      valid <= forward || hit;
    end
  end

  // Forwarded target beats the stale table entry
  always_ff @(posedge clk) begin
    target <= forward ? updateTarget : targets[lookupIndex];
  end

endmodule

/* bpred/dirPredictor.sv */
`timescale 1ns/1ns
`include "bpred_defs.svh"

// Table of two-bit saturating counters indexed by PC
module dirPredictor (
  input  logic               clk,
  input  logic               reset,
  input  bpredPkg::pcT       lookupPC,
  output bpredPkg::dirStateT prediction,
  input  bpredPkg::pcT       updatePC,
  input  logic               updateEn,
  input  logic               updateTaken,
  input  bpredPkg::dirStateT updateOld
);

  localparam int IndexBits = `BPRED_DIR_INDEX_BITS;
  localparam int Entries   = 1 << IndexBits;

  logic [IndexBits-1:0] lookupIndex;
  logic [IndexBits-1:0] updateIndex;
  bpredPkg::dirStateT   counters [Entries];
  bpredPkg::dirStateT   nextState;

  // Word aligned PCs, skip the two low bits
  assign lookupIndex = lookupPC[IndexBits+1:2];
  assign updateIndex = updatePC[IndexBits+1:2];

  //////////////////////////////////////////////////
  // Saturating step
  //////////////////////////////////////////////////

  // Move one step toward the resolved direction
  always_comb begin
    nextState = updateOld;
    if (updateTaken) begin
      if (updateOld != bpredPkg::stronglyTaken) begin
        nextState = bpredPkg::dirStateT'(updateOld + 2'd1);
      end
    end else begin
      if (updateOld != bpredPkg::stronglyNotTaken) begin
        nextState = bpredPkg::dirStateT'(updateOld - 2'd1);
      end
    end
  end

  //////////////////////////////////////////////////
  // Counter table
  //////////////////////////////////////////////////

  // Whole table returns to weakly not taken in one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < Entries; i++) begin
        counters[i] <= bpredPkg::weaklyNotTaken;
      end
    end else if (updateEn) begin
      counters[updateIndex] <= nextState;
    end
  end

  // Registered read, valid in the F cycle
  // A same-cycle update is not seen here
  always_ff @(posedge clk) begin
    if (reset) begin
      prediction <= bpredPkg::weaklyNotTaken;
    end else begin
      prediction <= counters[lookupIndex];
    end
  end

  // Saturation at the top must hold across the write
  assert property (@(posedge clk) disable iff (reset)
    (updateEn && updateTaken && updateOld == bpredPkg::stronglyTaken)
      |=> counters[$past(updateIndex)] == bpredPkg::stronglyTaken)
    else $error("dirPredictor: stronglyTaken left saturation on taken update");

endmodule

/* bpred/rasPredictor.sv */
`timescale 1ns/1ns
`include "bpred_defs.svh"

// Circular return address stack
module rasPredictor (
  input  logic         clk,
  input  logic         reset,
  input  logic         push,
  input  bpredPkg::pcT pushPC,
  input  logic         pop,
  output bpredPkg::pcT top
);

  localparam int Depth    = `BPRED_RAS_DEPTH;
  localparam int IdxBits  = $clog2(Depth);
  localparam int FillBits = $clog2(Depth + 1);

  bpredPkg::pcT        entries [Depth];
  // Circular index of the top entry
  logic [IdxBits-1:0]  topIdx;
  // Live entry count that saturates at Depth
  logic [FillBits-1:0] fill;

  logic                popLive;
  logic [IdxBits-1:0]  popIdx;
  logic [IdxBits-1:0]  nextIdx;
  logic [FillBits-1:0] popFill;
  logic [FillBits-1:0] nextFill;

  // Pop reads the current top
  assign top = entries[topIdx];

  //////////////////////////////////////////////////
  // Pointer update
  //////////////////////////////////////////////////

  // Empty pop leaves the pointer where it is
  assign popLive = pop && (fill != '0);
  assign popIdx  = popLive ? topIdx - IdxBits'(1) : topIdx;
  assign popFill = popLive ? fill - FillBits'(1) : fill;

  // Push goes on the entry after the post-pop top
  assign nextIdx  = push ? popIdx + IdxBits'(1) : popIdx;
  assign nextFill = (push && popFill != FillBits'(Depth)) ? popFill + FillBits'(1) : popFill;

  // Full stack wraps onto the oldest entry
  always_ff @(posedge clk) begin
    if (reset) begin
      topIdx <= '0;
      fill   <= '0;
      for (int i = 0; i < Depth; i++) begin
        entries[i] <= '0;
      end
    end else begin
      topIdx <= nextIdx;
      fill   <= nextFill;
      if (push) begin
        entries[nextIdx] <= pushPC;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) fill <= FillBits'(Depth))
    else $error("rasPredictor: stack pointer past depth");

endmodule

/* common/bpredPkg.sv */
`include "bpred_defs.svh"

package bpredPkg;

  //////////////////////////////////////////////////
  // Basic types
  //////////////////////////////////////////////////

  // Program counter
  typedef logic [`BPRED_XLEN-1:0] pcT;

  // Two-bit saturating counter state
  // Upper bit is the taken prediction
  typedef enum logic [1:0] {
    stronglyNotTaken = 2'b00,
    weaklyNotTaken   = 2'b01,
    weaklyTaken      = 2'b10,
    stronglyTaken    = 2'b11
  } dirStateT;

  // Control-flow class of a fetched instruction
  // All zero means not a control-flow instruction
  typedef struct packed {
    logic isReturn;
    logic isJumpReg;
    logic isJump;
    logic isCall;
    logic isBranch;
  } instrClassT;

  //////////////////////////////////////////////////
  // Pipeline payload
  //////////////////////////////////////////////////

  // Prediction state carried from F through D to E
  // Zero is a bubble with stronglyNotTaken
  typedef struct packed {
    dirStateT   dirState;
    instrClassT instrClass;
  } stagePredT;

endpackage

/* common/bpred_defs.svh */
`ifndef BPRED_DEFS_SVH
`define BPRED_DEFS_SVH

//////////////////////////////////////////////////
// Branch predictor sizing
//////////////////////////////////////////////////

// Architectural PC width, RV32
`define BPRED_XLEN 32

// Direction table index width
// 64 two-bit counters
`define BPRED_DIR_INDEX_BITS 6

// Target buffer index width
// 32 direct-mapped entries
`define BPRED_BTB_INDEX_BITS 5

// Return address stack entries
`define BPRED_RAS_DEPTH 4

`endif

/* tb.f */
+incdir+common
common/bpredPkg.sv
verilog/pipeStage.sv
bpred/dirPredictor.sv
bpred/btbPredictor.sv
bpred/rasPredictor.sv
bpred/bpred.sv
verification/tbClock.sv
verification/bpredTb.sv

/* verification/bpredTb.sv */
`timescale 1ns/1ns
`include "bpred_defs.svh"

module bpredTb;

  localparam logic [31:0] Nop = 32'h00000013;
  localparam int DirEntries = 1 << `BPRED_DIR_INDEX_BITS;
  localparam int BtbEntries = 1 << `BPRED_BTB_INDEX_BITS;
  localparam int Depth = `BPRED_RAS_DEPTH;

  // One instruction of the stream with its resolved outcome
  typedef struct packed {
    bpredPkg::pcT pc;
    logic [31:0]  instr;
    bpredPkg::pcT target;
    logic         taken;
    bpredPkg::pcT pcd;
    logic         mayStall;
    logic         killF;
    logic         killD;
  } recT;

  typedef struct packed {
    logic         sel;
    bpredPkg::pcT pc;
    logic         wrong;
  } expectT;

  logic clk;
  logic reset;
  logic StallF;
  logic StallD;
  logic StallE;
  logic FlushF;
  logic FlushD;
  logic FlushE;
  bpredPkg::pcT PCNextF;
  logic [31:0] InstrF;
  bpredPkg::pcT PCE;
  bpredPkg::pcT PCD;
  bpredPkg::pcT PCTargetE;
  bpredPkg::pcT PCLinkE;
  logic PCSrcE;
  bpredPkg::pcT BPPredPCF;
  logic SelBPPredF;
  logic BPPredWrongE;

  recT recs[$];
  integer seed = 32'h0cbb8999;
  bpredPkg::pcT nopPc = 32'h0000_1000;
  logic built = 1'b0;
  logic done = 1'b0;
  int vF = -1;
  int vD = -1;
  int vE = -1;
  int nextIdx = 0;
  int selHits = 0;
  int wrongHits = 0;

  // Reference state
  bpredPkg::dirStateT mCnt [DirEntries];
  logic mBtbV [BtbEntries];
  bpredPkg::pcT mBtbPc [BtbEntries];
  bpredPkg::pcT mBtbT [BtbEntries];
  bpredPkg::pcT mRas [Depth];
  int mTop;
  int mFill;
  bpredPkg::dirStateT mLookDir;
  logic mLookV;
  bpredPkg::pcT mLookT;
  bpredPkg::stagePredT mStD;
  bpredPkg::stagePredT mStE;

  tbClock u_clk (
    .clk  (clk),
    .reset(reset)
  );

  bpred u_dut (
    .clk         (clk),
    .reset       (reset),
    .StallF      (StallF),
    .StallD      (StallD),
    .StallE      (StallE),
    .FlushF      (FlushF),
    .FlushD      (FlushD),
    .FlushE      (FlushE),
    .PCNextF     (PCNextF),
    .InstrF      (InstrF),
    .PCE         (PCE),
    .PCD         (PCD),
    .PCTargetE   (PCTargetE),
    .PCLinkE     (PCLinkE),
    .PCSrcE      (PCSrcE),
    .BPPredPCF   (BPPredPCF),
    .SelBPPredF  (SelBPPredF),
    .BPPredWrongE(BPPredWrongE)
  );

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic checkBit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t: %s expected %b got %b", $time, what, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic checkPc(input string what, input bpredPkg::pcT exp, input bpredPkg::pcT act);
    if (act !== exp) begin
      $display("ERR %0t: %s expected %h got %h", $time, what, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic checkState(input string what, input bpredPkg::dirStateT exp,
                            input bpredPkg::dirStateT act);
    if (act !== exp) begin
      $display("ERR %0t: %s expected %s got %s", $time, what, exp.name(), act.name());
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // RV32 control-flow class from the raw encoding
  function automatic bpredPkg::instrClassT decodeClass(input logic [31:0] instr);
    bpredPkg::instrClassT c;
    logic jal;
    logic jalr;
    jal = instr[6:0] == 7'h6F;
    jalr = instr[6:0] == 7'h67;
    c.isReturn = jalr && instr[19:15] == 5'd1 && instr[11:7] == 5'd0;
    c.isJumpReg = jalr && !c.isReturn;
    c.isJump = jal;
    c.isCall = (jal || jalr) && instr[11:7] == 5'd1;
    c.isBranch = instr[6:0] == 7'h63;
    return c;
  endfunction

  // Saturating two-bit step
  function automatic bpredPkg::dirStateT stepCounter(input bpredPkg::dirStateT s,
                                                     input logic taken);
    if (taken) begin
      return (s == bpredPkg::stronglyTaken) ? s : bpredPkg::dirStateT'(s + 2'd1);
    end
    return (s == bpredPkg::stronglyNotTaken) ? s : bpredPkg::dirStateT'(s - 2'd1);
  endfunction

  // Expected outputs for the current cycle
  function automatic expectT predictModel();
    expectT e;
    bpredPkg::instrClassT c;
    bpredPkg::pcT correct;
    c = decodeClass(InstrF);
    e.sel = c.isReturn ||
            (mLookV && ((c.isBranch && mLookDir[1]) || c.isJump || c.isJumpReg));
    e.pc = c.isReturn ? mRas[mTop] : mLookT;
    correct = PCSrcE ? PCTargetE : PCLinkE;
    e.wrong = (mStE.instrClass != '0) &&
              ((PCD != correct) ||
               (mStE.instrClass.isBranch && (mStE.dirState[1] != PCSrcE)));
    return e;
  endfunction

  // Model clock edge while inputs still hold pre-edge values
  task automatic modelClock();
    bpredPkg::instrClassT c;
    logic commit;
    logic btbUpd;
    logic fwd;
    int li;
    int bi;
    int ui;
    bpredPkg::stagePredT newD;
    bpredPkg::stagePredT newE;
    if (reset) begin
      foreach (mCnt[i]) mCnt[i] = bpredPkg::weaklyNotTaken;
      foreach (mBtbV[i]) mBtbV[i] = 1'b0;
      foreach (mRas[i]) mRas[i] = '0;
      mTop = 0;
      mFill = 0;
      mLookDir = bpredPkg::weaklyNotTaken;
      mLookV = 1'b0;
      mLookT = '0;
      mStD = '0;
      mStE = '0;
    end else begin
      c = decodeClass(InstrF);
      commit = !StallE && !FlushE;
      // Stage registers first so they see the old lookup
      newE = FlushD ? '0 : (!StallD ? mStD : mStE);
      newD = FlushF ? '0 : (!StallF ? {mLookDir, c} : mStD);
      // Return address stack pops before it pushes
      if (c.isReturn && !StallF && mFill > 0) begin
        mTop = (mTop + Depth - 1) % Depth;
        mFill--;
      end
      if (mStE.instrClass.isCall && commit) begin
        mTop = (mTop + 1) % Depth;
        mRas[mTop] = PCLinkE;
        if (mFill < Depth) mFill++;
      end
      // Direction lookup reads before the update lands
      li = int'(PCNextF[`BPRED_DIR_INDEX_BITS+1:2]);
      mLookDir = mCnt[li];
      if (mStE.instrClass.isBranch && commit) begin
        ui = int'(PCE[`BPRED_DIR_INDEX_BITS+1:2]);
        mCnt[ui] = stepCounter(mStE.dirState, PCSrcE);
      end
      // Target buffer with same-PC forwarding
      btbUpd = commit && (mStE.instrClass.isBranch || mStE.instrClass.isJump ||
                          mStE.instrClass.isJumpReg);
      fwd = btbUpd && (PCE[31:2] == PCNextF[31:2]);
      bi = int'(PCNextF[`BPRED_BTB_INDEX_BITS+1:2]);
      mLookV = fwd || (mBtbV[bi] && mBtbPc[bi][31:2] == PCNextF[31:2]);
      mLookT = fwd ? PCTargetE : mBtbT[bi];
      if (btbUpd) begin
        ui = int'(PCE[`BPRED_BTB_INDEX_BITS+1:2]);
        mBtbV[ui] = 1'b1;
        mBtbPc[ui] = PCE;
        mBtbT[ui] = PCTargetE;
      end
      mStD = newD;
      mStE = newE;
    end
  endtask

  //////////////////////////////////////////////////
  // Stream building
  //////////////////////////////////////////////////

  task automatic addRec(input bpredPkg::pcT pc, input logic [31:0] instr,
                        input bpredPkg::pcT target, input logic taken,
                        input logic pcdWrong, input logic mayStall,
                        input logic killF, input logic killD);
    recT r;
    r.pc = pc;
    r.instr = instr;
    r.target = target;
    r.taken = taken;
    r.pcd = pcdWrong ? bpredPkg::pcT'($random(seed)) : (taken ? target : pc + 32'd4);
    r.mayStall = mayStall;
    r.killF = killF;
    r.killD = killD;
    recs.push_back(r);
  endtask

  task automatic addNops(input int n);
    for (int i = 0; i < n; i++) begin
      addRec(nopPc, Nop, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      nopPc = nopPc + 32'd4;
    end
  endtask

  task automatic buildStream();
    logic [31:0] instr;
    logic taken;
    bpredPkg::pcT pc;
    int k;
    // Bubbles and plain instructions after reset
    addNops(6);
    // Train one branch taken, then back to not taken
    for (int i = 0; i < 3; i++) begin
      addRec(32'h100, 32'h00000063, 32'h200, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      addNops(4);
    end
    for (int i = 0; i < 3; i++) begin
      addRec(32'h100, 32'h00000063, 32'h200, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      addNops(4);
    end
    // Randomized mix over a few PCs so the tables hit
    for (int i = 0; i < 48; i++) begin
      k = $unsigned($random(seed)) % 4;
      pc = 32'h40 + 32'd4 * ($unsigned($random(seed)) % 8);
      case (k)
        0: instr = 32'h00000063;
        1: instr = 32'h0000006F;
        2: instr = 32'h00028067;
        default: instr = Nop;
      endcase
      taken = (k == 0) ? 1'($random(seed)) : (k != 3);
      addRec(pc, instr, 32'h800 + 32'd4 * ($unsigned($random(seed)) % 4), taken,
             ($random(seed) & 3) == 0, 1'b1, 1'b0, 1'b0);
    end
    addNops(4);
    // Single call and return
    addRec(32'h300, 32'h000000EF, 32'h500, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    addNops(3);
    addRec(32'h504, 32'h00008067, 32'h304, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    addNops(3);
    // Nested calls returned in LIFO order
    for (int i = 0; i < Depth; i++) begin
      instr = (i % 2 == 0) ? 32'h000000EF : 32'h000280E7;
      addRec(32'h600 + 32'h10 * i, instr, 32'h700 + 32'h10 * i, 1'b1, 1'b0, 1'b0,
             1'b0, 1'b0);
      addNops(3);
    end
    for (int i = Depth - 1; i >= 0; i--) begin
      addRec(32'h900 + 32'h10 * i, 32'h00008067, 32'h604 + 32'h10 * i, 1'b1, 1'b0,
             1'b0, 1'b0, 1'b0);
      addNops(3);
    end
    // Flushed instructions become bubbles
    addRec(32'h100, 32'h00000063, 32'h200, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
    addNops(2);
    addRec(32'h44, 32'h0000006F, 32'h880, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
    addNops(2);
    // Stalls hold class and counter state
    for (int i = 0; i < 12; i++) begin
      addRec(32'h100, 32'h00000063, 32'h200, 1'($random(seed)), 1'b0, 1'b1, 1'b0, 1'b0);
    end
    addNops(6);
  endtask

  //////////////////////////////////////////////////
  // Pipeline driver
  //////////////////////////////////////////////////

  initial begin
    StallF = 1'b0;
    StallD = 1'b0;
    StallE = 1'b0;
    FlushF = 1'b0;
    FlushD = 1'b0;
    FlushE = 1'b0;
    PCNextF = '0;
    InstrF = Nop;
    PCE = '0;
    PCD = '0;
    PCTargetE = '0;
    PCLinkE = '0;
    PCSrcE = 1'b0;
  end

  always @(posedge clk) begin
    logic stallNext;
    modelClock();
    if (!reset && built && !done) begin
      // Follow the controls that were live this cycle
      if (FlushD) vE = -1;
      else if (!StallD) vE = vD;
      if (FlushF) vD = -1;
      else if (!StallF) vD = vF;
      if (!StallF) begin
        vF = (nextIdx < recs.size()) ? nextIdx : -1;
        if (nextIdx < recs.size()) nextIdx++;
      end
      stallNext = vF >= 0 && recs[vF].mayStall && ($random(seed) & 7) == 0;
      StallF <= stallNext;
      StallD <= stallNext;
      StallE <= stallNext;
      FlushF <= !stallNext && vF >= 0 && recs[vF].killF;
      FlushD <= !stallNext && vD >= 0 && recs[vD].killD;
      InstrF <= (vF >= 0) ? recs[vF].instr : Nop;
      if (stallNext) PCNextF <= (vF >= 0) ? recs[vF].pc : '0;
      else PCNextF <= (nextIdx < recs.size()) ? recs[nextIdx].pc : '0;
      // Execute side plays the resolved outcome
      PCE <= (vE >= 0) ? recs[vE].pc : '0;
      PCTargetE <= (vE >= 0) ? recs[vE].target : '0;
      PCLinkE <= (vE >= 0) ? recs[vE].pc + 32'd4 : '0;
      PCSrcE <= (vE >= 0) ? recs[vE].taken : 1'b0;
      // A bubble in E sees a PCD that any live instruction would flag
      PCD <= (vE >= 0) ? recs[vE].pcd : 32'hFFFF_FFFC;
      if (vF < 0 && vD < 0 && vE < 0 && nextIdx >= recs.size()) done <= 1'b1;
    end
  end

  // Outputs are settled mid-cycle
  always @(negedge clk) begin
    expectT e;
    if (!reset) begin
      e = predictModel();
      if (e.sel) selHits++;
      if (e.wrong) wrongHits++;
      checkBit("SelBPPredF", e.sel, SelBPPredF);
      if (e.sel) checkPc("BPPredPCF", e.pc, BPPredPCF);
      checkBit("BPPredWrongE", e.wrong, BPPredWrongE);
      checkState("E stage counter", mStE.dirState, u_dut.stageE.dirState);
    end
  end

  initial begin
    buildStream();
    built = 1'b1;
    wait (done);
    repeat (3) @(posedge clk);
    if (selHits > 0 && wrongHits > 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("No prediction or misprediction was ever expected by the stream");
      $display("SIMULATION FAILED");
      $fatal(1, "stream coverage");
    end
  end

  // Watchdog sized from the stream
  initial begin
    wait (built);
    #(recs.size() * 40 * 20);
    $display("Timeout: the instruction stream did not drain in time");
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

endmodule

/* verification/tbClock.sv */
`timescale 1ns/1ns

// Free-running clock and power-on reset
module tbClock (
  output logic clk,
  output logic reset
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // Reset held for five rising edges
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* verilog/pipeStage.sv */
`timescale 1ns/1ns

// Pipeline register for any packed payload
module pipeStage #(
  parameter type payloadT = logic [7:0]
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    en,
  input  logic    clear,
  input  payloadT d,
  output payloadT q
);

  // Clear wins over enable, stall holds
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      q <= '0;
    end else if (en) begin
      q <= d;
    end
  end

  // Bubble out of reset so later stages start clean
  assert property (@(posedge clk) reset |=> q == '0)
    else $error("pipeStage: payload not cleared after reset");

endmodule
